//--- verilog/huf_pkg.sv
`default_nettype none

package huf_pkg;

  // ========================================
  // Table geometry
  // ========================================
  localparam int NUM_SYMS    = 16;
  localparam int SYM_WIDTH   = 4;
  localparam int PTR_WIDTH   = 5;   // Must also hold NUM_SYMS itself
  localparam int FREQ_WIDTH  = 12;
  localparam int DEPTH_WIDTH = 5;
  localparam int RCNT_WIDTH  = 4;

  // ========================================
  // Work table rows
  // ========================================
  // A leaf carries its symbol code in index, a node the row where it was made
  typedef struct packed {
    logic                  is_node;
    logic [PTR_WIDTH-1:0]  index;
    logic [FREQ_WIDTH-1:0] weight;
  } work_entry_t;

  typedef work_entry_t [NUM_SYMS-1:0] work_table_t;

  // Code length per symbol code
  typedef logic [NUM_SYMS-1:0][DEPTH_WIDTH-1:0] depth_vec_t;

endpackage

`default_nettype wire

//--- verilog/huf_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Table handed from the load stage to the merge stage
interface huf_table_if;
  import huf_pkg::*;

  work_table_t          entries;       // Scaled for the current pass
  logic [PTR_WIDTH-1:0] start_row;
  logic                 zero_symbols;
  logic                 load;          // One cycle per captured start

  modport src (
    output entries,
    output start_row,
    output zero_symbols,
    output load
  );

  modport dst (
    input entries,
    input start_row,
    input zero_symbols,
    input load
  );
endinterface

// Merge results forward, depth status back
interface huf_merge_if;
  import huf_pkg::*;

  logic                   merge_valid;
  work_entry_t [1:0]      pair;        // The two children
  logic [PTR_WIDTH-1:0]   parent_row;
  logic                   clear;
  logic                   rebuild;     // Current depths break the limit
  logic                   fail;

  modport src (
    output merge_valid,
    output pair,
    output parent_row,
    output clear,
    input  rebuild,
    input  fail
  );

  modport dst (
    input  merge_valid,
    input  pair,
    input  parent_row,
    input  clear,
    output rebuild,
    output fail
  );
endinterface

`default_nettype wire

//--- verilog/huf_load_decode.sv
`timescale 1ns/1ps
`default_nettype none

module huf_load_decode (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  start,
  input  logic                                                  busy,
  input  logic [huf_pkg::PTR_WIDTH-1:0]                         start_row,
  input  logic [huf_pkg::NUM_SYMS-1:0][huf_pkg::SYM_WIDTH-1:0]  sort_sym,
  input  logic [huf_pkg::NUM_SYMS-1:0][huf_pkg::FREQ_WIDTH-1:0] sort_freq,
  input  logic [huf_pkg::RCNT_WIDTH-1:0]                        rebuild_cnt,
  huf_table_if.src                                              tbl
);
  import huf_pkg::*;

  logic [NUM_SYMS-1:0][SYM_WIDTH-1:0]  sym_q;
  logic [NUM_SYMS-1:0][FREQ_WIDTH-1:0] freq_q;
  logic [PTR_WIDTH-1:0]                row_q;
  logic                                zero_q;
  logic                                load_q;
  logic [RCNT_WIDTH-1:0]               shift;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      load_q <= 1'b0;
      row_q  <= '0;
      zero_q <= 1'b0;
    end
    else
    begin
      load_q <= start && !busy;
      if (start && !busy)
      begin
        row_q  <= start_row;
        zero_q <= (start_row == PTR_WIDTH'(NUM_SYMS));
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start && !busy)
    begin
      sym_q  <= sort_sym;
      freq_q <= sort_freq;
    end
  end

  // Count is still stale in the load cycle, a fresh table goes out unscaled
  assign shift = load_q ? '0 : rebuild_cnt;

  always_comb
  begin
    tbl.entries = '0;
    for (int i = 0; i < NUM_SYMS; i++)
    begin
      if (PTR_WIDTH'(i) >= row_q)
      begin
        tbl.entries[i].index  = PTR_WIDTH'(sym_q[i]);
        tbl.entries[i].weight = freq_q[i] >> shift;
        if (freq_q[i] != '0 && tbl.entries[i].weight == '0)
          tbl.entries[i].weight = FREQ_WIDTH'(1); // Floor
      end
    end
  end

  assign tbl.start_row    = row_q;
  assign tbl.zero_symbols = zero_q;
  assign tbl.load         = load_q;

endmodule

`default_nettype wire

//--- verilog/huf_merge_execute.sv
`timescale 1ns/1ps
`default_nettype none

module huf_merge_execute (
  input  logic     clk,
  input  logic     rst_n,
  huf_table_if.dst tbl,
  huf_merge_if.src mrg,
  output logic     busy,
  output logic     done,
  output logic     rebuild_pulse
);
  import huf_pkg::*;

  typedef enum logic [2:0] {IDLE, BUILD, PIPE_WAIT, CHECK, REBUILD} state_t;

  state_t                   state;
  state_t                   state_nxt;
  work_table_t              work_q;
  work_table_t              work_nxt;
  work_entry_t [NUM_SYMS:0] work_ext;
  logic [NUM_SYMS:0]        below;
  logic [PTR_WIDTH-1:0]     row_ptr;
  logic [PTR_WIDTH-1:0]     row_ptr_inc;
  work_entry_t              child0;
  work_entry_t              child1;
  work_entry_t              parent;
  logic                     reload;
  logic                     merge_go;
  logic                     last_merge;

  // ========================================
  // Merge selection
  // ========================================
  // Extra empty row past the end stands in for a missing second child
  assign work_ext    = {work_entry_t'('0), work_q};
  assign row_ptr_inc = row_ptr + 1'b1;
  assign child0      = work_ext[row_ptr];
  assign child1      = work_ext[row_ptr_inc];
  assign last_merge  = (row_ptr >= PTR_WIDTH'(NUM_SYMS - 2));

  always_comb
  begin
    parent         = '0;
    parent.is_node = 1'b1;
    parent.index   = row_ptr;                        // Node id is its birth row
    parent.weight  = child0.weight + child1.weight;
  end

  always_comb
  begin
    below = '0;
    for (int i = 0; i < NUM_SYMS; i++)
      below[i] = (work_q[i].weight <= parent.weight);
  end

  // Rows lighter or equal slide down one, the parent fills the gap
  always_comb
  begin
    work_nxt = work_q;
    for (int i = 0; i < NUM_SYMS; i++)
    begin
      if (PTR_WIDTH'(i) > row_ptr)
      begin
        if (below[i+1])
          work_nxt[i] = work_ext[i+1];
        else if (PTR_WIDTH'(i) == row_ptr_inc || below[i])
          work_nxt[i] = parent;
      end
    end
  end

  // ========================================
  // Control
  // ========================================
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:      if (tbl.load) state_nxt = BUILD;
      BUILD:
        if (tbl.zero_symbols)
          state_nxt = IDLE;
        else if (last_merge)
          state_nxt = PIPE_WAIT;
      PIPE_WAIT: state_nxt = mrg.fail ? IDLE : (mrg.rebuild ? REBUILD : CHECK);
      CHECK:     state_nxt = mrg.fail ? IDLE : (mrg.rebuild ? REBUILD : IDLE);
      REBUILD:   state_nxt = BUILD;
      default:   state_nxt = IDLE;
    endcase
  end

  assign reload   = ((state == IDLE) && tbl.load) || (state == REBUILD);
  assign merge_go = (state == BUILD) && !tbl.zero_symbols;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      row_ptr <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (reload)
        row_ptr <= tbl.start_row;
      else if (merge_go)
        row_ptr <= row_ptr_inc;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reload)
      work_q <= tbl.entries;
    else if (merge_go)
      work_q <= work_nxt;
  end

  assign busy            = (state != IDLE) || tbl.load;
  assign done            = (state != IDLE) && (state_nxt == IDLE);
  assign rebuild_pulse   = (state == REBUILD);

  assign mrg.merge_valid = merge_go;
  assign mrg.pair        = {child1, child0};
  assign mrg.parent_row  = row_ptr;
  assign mrg.clear       = reload;

endmodule

`default_nettype wire

//--- verilog/huf_depth_result.sv
`timescale 1ns/1ps
`default_nettype none

module huf_depth_result (
  input  logic                             clk,
  input  logic                             rst_n,
  huf_merge_if.dst                         mrg,
  input  logic [huf_pkg::DEPTH_WIDTH-1:0]  max_code_length,
  input  logic [huf_pkg::RCNT_WIDTH-1:0]   max_rebuild_limit,
  output logic [huf_pkg::RCNT_WIDTH-1:0]   rebuild_cnt,
  output huf_pkg::depth_vec_t              sym_depth,
  output logic                             build_error
);
  import huf_pkg::*;

  logic                                valid_q;
  work_entry_t [1:0]                   pair_q;
  logic [PTR_WIDTH-1:0]                parent_q;
  logic [NUM_SYMS-1:0]                 node_val, node_val_c;
  logic [NUM_SYMS-1:0][PTR_WIDTH-1:0]  node_id, node_id_c;
  depth_vec_t                          depth_c;
  logic                                too_long;
  logic                                rebuild_q;
  logic                                fail_q;
  logic                                load_clear;

  // Second stage of the merge, one behind the selection
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else
      valid_q <= mrg.merge_valid;
  end

  always_ff @(posedge clk)
  begin
    pair_q   <= mrg.pair;
    parent_q <= mrg.parent_row;
  end

  // ========================================
  // Node table and depth update
  // ========================================
  always_comb
  begin
    node_val_c = node_val;
    node_id_c  = node_id;
    depth_c    = sym_depth;
    if (mrg.clear)
    begin
      node_val_c = '0;
      depth_c    = '0;
    end
    else if (valid_q)
    begin
      for (int j = 0; j < 2; j++)
      begin
        for (int s = 0; s < NUM_SYMS; s++)
        begin
          if (!pair_q[j].is_node && pair_q[j].weight != '0 &&
              pair_q[j].index == PTR_WIDTH'(s))
          begin
            node_val_c[s] = 1'b1;       // Leaf joins its first node
            node_id_c[s]  = parent_q;
            depth_c[s]    = DEPTH_WIDTH'(1);
          end
          else if (pair_q[j].is_node && node_val[s] && node_id[s] == pair_q[j].index)
          begin
            node_id_c[s] = parent_q;
            depth_c[s]   = sym_depth[s] + 1'b1;
          end
        end
      end
    end
  end

  always_comb
  begin
    too_long = 1'b0;
    for (int s = 0; s < NUM_SYMS; s++)
      if (depth_c[s] > max_code_length)
        too_long = 1'b1;
  end

  // ========================================
  // Rebuild count
  // ========================================
  // Only a REBUILD clear sees rebuild high without fail
  assign load_clear = mrg.clear && !(rebuild_q && !fail_q);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      node_val    <= '0;
      sym_depth   <= '0;
      rebuild_q   <= 1'b0;
      fail_q      <= 1'b0;
      rebuild_cnt <= '0;
    end
    else
    begin
      node_val  <= node_val_c;
      sym_depth <= depth_c;
      if (mrg.clear)
        rebuild_q <= 1'b0;
      else if (valid_q)                   // Status moves only with an applied merge
        rebuild_q <= too_long;
      if (load_clear)
      begin
        rebuild_cnt <= '0;
        fail_q      <= 1'b0;
      end
      else if (valid_q && too_long && !rebuild_q)    // First violation of this pass
      begin
        if (rebuild_cnt > max_rebuild_limit)
          fail_q <= 1'b1;
        else
          rebuild_cnt <= rebuild_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    node_id <= node_id_c;
  end

  assign mrg.rebuild = rebuild_q;
  assign mrg.fail    = fail_q;
  assign build_error = fail_q;

endmodule

`default_nettype wire

//--- verilog/huf_tree_top.sv
`timescale 1ns/1ps
`default_nettype none

module huf_tree_top (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  start,
  input  logic [huf_pkg::PTR_WIDTH-1:0]                         start_row,
  input  logic [huf_pkg::NUM_SYMS-1:0][huf_pkg::SYM_WIDTH-1:0]  sort_sym,
  input  logic [huf_pkg::NUM_SYMS-1:0][huf_pkg::FREQ_WIDTH-1:0] sort_freq,
  input  logic [huf_pkg::DEPTH_WIDTH-1:0]                       max_code_length,
  input  logic [huf_pkg::RCNT_WIDTH-1:0]                        max_rebuild_limit,
  output logic                                                  busy,
  output logic                                                  done,
  output logic                                                  rebuild_pulse,
  output logic                                                  zero_symbols,
  output logic                                                  build_error,
  output huf_pkg::depth_vec_t                                   sym_depth
);
  import huf_pkg::*;

  huf_table_if tbl_if ();
  huf_merge_if mrg_if ();

  logic [RCNT_WIDTH-1:0] rebuild_cnt;

  huf_load_decode u_load (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .busy        (busy),
    .start_row   (start_row),
    .sort_sym    (sort_sym),
    .sort_freq   (sort_freq),
    .rebuild_cnt (rebuild_cnt),
    .tbl         (tbl_if.src)
  );

  huf_merge_execute u_merge (
    .clk           (clk),
    .rst_n         (rst_n),
    .tbl           (tbl_if.dst),
    .mrg           (mrg_if.src),
    .busy          (busy),
    .done          (done),
    .rebuild_pulse (rebuild_pulse)
  );

  huf_depth_result u_depth (
    .clk               (clk),
    .rst_n             (rst_n),
    .mrg               (mrg_if.dst),
    .max_code_length   (max_code_length),
    .max_rebuild_limit (max_rebuild_limit),
    .rebuild_cnt       (rebuild_cnt),
    .sym_depth         (sym_depth),
    .build_error       (build_error)
  );

  assign zero_symbols = tbl_if.zero_symbols;  // Held from load until next start

endmodule

`default_nettype wire

//--- bench/huf_tree_sva.sv
`timescale 1ns/1ps
`default_nettype none

module huf_tree_sva (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic busy,
  input logic done,
  input logic rebuild_pulse
);

  busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    (start && !busy) |=> busy)
    else $error("busy did not rise after an accepted start");

  done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
    else $error("done came while busy was low");

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done lasted more than one cycle");

  busy_falls: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
    else $error("busy stayed high after done");

  pulse_in_busy: assert property (@(posedge clk) disable iff (!rst_n) rebuild_pulse |-> busy)
    else $error("rebuild_pulse came while busy was low");

endmodule

`default_nettype wire

//--- bench/huf_tree_checker.sv
`timescale 1ns/1ps
`default_nettype none

module huf_tree_checker (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start,
  input  logic                            busy,
  input  logic                            done,
  input  logic                            rebuild_pulse,
  input  logic                            zero_symbols,
  input  logic                            build_error,
  input  huf_pkg::depth_vec_t             sym_depth,
  input  logic [huf_pkg::DEPTH_WIDTH-1:0] max_code_length,
  input  huf_pkg::depth_vec_t             exp_depth,
  input  logic [7:0]                      exp_pulses,
  input  logic                            exp_err,
  input  logic                            exp_zero,
  output int                              error_count,
  output int                              check_count
);
  import huf_pkg::*;

  logic [7:0] pulses;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_result();
    logic [31:0] kraft;
    int          used;
    kraft = '0;
    used  = 0;
    compare_value("zero_symbols", 32'(zero_symbols), 32'(exp_zero));
    compare_value("build_error", 32'(build_error), 32'(exp_err));
    compare_value("rebuild_pulse count", 32'(pulses), 32'(exp_pulses));
    if (!exp_err)
    begin
      for (int s = 0; s < NUM_SYMS; s++)
      begin
        compare_value($sformatf("sym_depth[%0d]", s), 32'(sym_depth[s]), 32'(exp_depth[s]));
        if (sym_depth[s] != '0 && sym_depth[s] <= 20)
        begin
          kraft = kraft + (32'd1 << (20 - sym_depth[s]));
          used++;
        end
        if (sym_depth[s] > max_code_length)
        begin
          error_count++;
          $display("Code length of symbol %0d is above the limit", s);
        end
      end
      // Lone symbol gets depth 1, so its sum is a half
      if (used > 1 && kraft != (32'd1 << 20))
      begin
        error_count++;
        $display("Code lengths do not form a complete prefix code");
      end
    end
  endtask

  // Sample away from the driving edge
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      pulses      = '0;
      error_count = 0;
      check_count = 0;
    end
    else
    begin
      if (start && !busy)
        pulses = '0;
      else if (rebuild_pulse)
        pulses = pulses + 1'b1;
      if (done)
        check_result();
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_huf_tree.sv
`timescale 1ns/1ps
`default_nettype none

module tb_huf_tree;
  import huf_pkg::*;

  localparam int CASE_WORDS = 53;

  logic                                clk;
  logic                                rst_n;
  logic                                start;
  logic [PTR_WIDTH-1:0]                start_row;
  logic [NUM_SYMS-1:0][SYM_WIDTH-1:0]  sort_sym;
  logic [NUM_SYMS-1:0][FREQ_WIDTH-1:0] sort_freq;
  logic [DEPTH_WIDTH-1:0]              max_code_length;
  logic [RCNT_WIDTH-1:0]               max_rebuild_limit;
  logic                                busy;
  logic                                done;
  logic                                rebuild_pulse;
  logic                                zero_symbols;
  logic                                build_error;
  depth_vec_t                          sym_depth;
  depth_vec_t                          exp_depth;
  logic [7:0]                          exp_pulses;
  logic                                exp_err;
  logic                                exp_zero;
  int                                  error_count;
  int                                  check_count;
  logic [11:0]                         cases_mem [0:511];
  int                                  num_cases;
  int                                  cycle_limit;
  int                                  cycles;

  huf_tree_top huf_tree_top_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .start             (start),
    .start_row         (start_row),
    .sort_sym          (sort_sym),
    .sort_freq         (sort_freq),
    .max_code_length   (max_code_length),
    .max_rebuild_limit (max_rebuild_limit),
    .busy              (busy),
    .done              (done),
    .rebuild_pulse     (rebuild_pulse),
    .zero_symbols      (zero_symbols),
    .build_error       (build_error),
    .sym_depth         (sym_depth)
  );

  huf_tree_checker checker_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .start           (start),
    .busy            (busy),
    .done            (done),
    .rebuild_pulse   (rebuild_pulse),
    .zero_symbols    (zero_symbols),
    .build_error     (build_error),
    .sym_depth       (sym_depth),
    .max_code_length (max_code_length),
    .exp_depth       (exp_depth),
    .exp_pulses      (exp_pulses),
    .exp_err         (exp_err),
    .exp_zero        (exp_zero),
    .error_count     (error_count),
    .check_count     (check_count)
  );

  bind huf_tree_top huf_tree_sva sva_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .busy          (busy),
    .done          (done),
    .rebuild_pulse (rebuild_pulse)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ========================================
  // Timeout
  // ========================================
  initial
    cycles = 0;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  // One case from the data file, driven 2 ns after the edge
  task automatic run_case(input int base);
    @(posedge clk);
    #2;
    start_row         = PTR_WIDTH'(cases_mem[base]);
    max_code_length   = DEPTH_WIDTH'(cases_mem[base+1]);
    max_rebuild_limit = RCNT_WIDTH'(cases_mem[base+2]);
    exp_pulses        = 8'(cases_mem[base+3]);
    exp_err           = cases_mem[base+4][0];
    for (int r = 0; r < NUM_SYMS; r++)
    begin
      sort_sym[r]  = SYM_WIDTH'(cases_mem[base+5+r]);
      sort_freq[r] = cases_mem[base+21+r];
      exp_depth[r] = DEPTH_WIDTH'(cases_mem[base+37+r]);
    end
    exp_zero = (exp_depth == '0);   // No used symbol leaves every length at 0
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    do
      @(negedge clk);
    while (!done);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial
  begin
    start             = 1'b0;
    start_row         = '0;
    sort_sym          = '0;
    sort_freq         = '0;
    max_code_length   = '0;
    max_rebuild_limit = '0;
    exp_depth         = '0;
    exp_pulses        = '0;
    exp_err           = 1'b0;
    exp_zero          = 1'b0;
    rst_n             = 1'b0;
    $readmemh("bench/huf_tree_cases.txt", cases_mem);
    num_cases   = int'(cases_mem[0]);
    cycle_limit = 20;
    for (int k = 0; k < num_cases; k++)
      cycle_limit += NUM_SYMS * (int'(cases_mem[1+k*CASE_WORDS+2]) + 1) + 10;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int k = 0; k < num_cases; k++)
      run_case(1 + k * CASE_WORDS);
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
verilog/huf_pkg.sv
verilog/huf_ifs.sv
verilog/huf_load_decode.sv
verilog/huf_merge_execute.sv
verilog/huf_depth_result.sv
verilog/huf_tree_top.sv
bench/huf_tree_sva.sv
bench/huf_tree_checker.sv
bench/tb_huf_tree.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run from the project root
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_huf_tree \
  -f build.f -o sim_huf_tree \
  && ./obj_dir/sim_huf_tree > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0

//--- bench/huf_tree_cases.txt
// Case count, then per case: start_row max_code_length rebuild_limit pulses error,
// symbols by row, frequencies by row, expected depths by symbol code
6
// Plain build on 8 symbols
08 0f 3 0 0
0 0 0 0 0 0 0 0 3 9 0 c 5 e 7 a
000 000 000 000 000 000 000 000 002 003 007 008 00d 010 015 028
4 0 0 5 0 3 0 2 0 5 2 0 3 0 3 0
// Full table of equal weights
00 0f 3 0 0
f e d c b a 9 8 7 6 5 4 3 2 1 0
005 005 005 005 005 005 005 005 005 005 005 005 005 005 005 005
4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 4
// One used symbol
0f 0f 3 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 064
0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
// Zero symbols
10 0f 3 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
// Skewed table under a length limit of 5
08 05 3 3 0
0 0 0 0 0 0 0 0 2 b 4 d 1 f 8 6
000 000 000 000 000 000 000 000 001 002 004 008 010 020 040 080
0 4 5 0 5 0 1 0 2 0 0 5 0 5 0 4
// Limit that cannot be met
08 02 1 2 1
0 0 0 0 0 0 0 0 0 1 2 3 4 5 6 7
000 000 000 000 000 000 000 000 007 007 007 007 007 007 007 007
3 3 3 3 3 3 3 3 0 0 0 0 0 0 0 0
